//--- bench/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Released on a falling edge, clear of the DUT's rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/control_checker.sv
`timescale 1ns/100ps
`default_nettype none

module control_checker #(
    parameter int NUM_INSTR = 200
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire ctrl_pkg::ctrl_word_t                  ctrl,
    input  wire cpu_isa_pkg::decoded_t [NUM_INSTR-1:0] instr_list,
    input  wire [NUM_INSTR-1:0]                        ovf_list,
    output logic                                       done,
    output int                                         checks,
    output int                                         errors
);

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int MAX_SEQ = 16;   // Overflow trap is the longest path

    typedef struct packed {
        logic [4:0]               len;
        ctrl_word_t [MAX_SEQ-1:0] words;
    } word_seq_t;

    // Expected ctrl words of one instruction, from fetch to its last cycle
    function automatic word_seq_t expected_sequence(instr_class_t cls, alu_op_t op, logic ovf);
        word_seq_t  seq;
        ctrl_word_t w;
        int         n;
        int         i;
        logic       trap;
        seq  = '0;
        n    = 0;
        trap = (cls == CLS_ILLEGAL) || (ovf && (cls == CLS_ALU_R || cls == CLS_ADDI));
        w           = '0;   // iord and ALU A select PC
        w.alu_src_b = SRCB_FOUR;
        w.alu_op    = ALU_ADD;
        for (i = 0; i < FETCH_WAIT; i++) begin
            seq.words[n] = w;
            n++;
        end
        w.pc_write   = 1'b1;
        w.ir_write   = 1'b1;
        seq.words[n] = w;
        n++;
        w            = '0;
        w.a_write    = 1'b1;
        w.b_write    = 1'b1;
        seq.words[n] = w;
        n = n + 2;   // Dispatch word stays zero
        w = '0;
        if (cls inside {CLS_ALU_R, CLS_ADDI, CLS_ADDIU, CLS_LW, CLS_SW}) begin
            w.alu_src_a     = SRCA_A;
            w.alu_src_b     = (cls == CLS_ALU_R) ? SRCB_B : SRCB_IMM;
            w.alu_op        = (cls == CLS_ALU_R) ? op : ALU_ADD;
            w.alu_reg_write = 1'b1;
            seq.words[n]    = w;
            n++;
            w = '0;
        end
        if (!trap && cls inside {CLS_ALU_R, CLS_ADDI, CLS_ADDIU}) begin
            w.reg_write  = 1'b1;
            w.reg_dst    = (cls == CLS_ALU_R) ? DST_RD : DST_RT;
            w.mem_to_reg = WB_ALU_OUT;
            seq.words[n] = w;
            n++;
        end
        if (cls == CLS_LW) begin
            w.iord = ADDR_ALU_OUT;
            for (i = 0; i < MEM_WAIT; i++) begin
                seq.words[n] = w;
                n++;
            end
            w.mdr_write  = 1'b1;
            seq.words[n] = w;
            n++;
            w            = '0;
            w.reg_write  = 1'b1;
            w.mem_to_reg = WB_MDR;   // Into rt
            seq.words[n] = w;
            n++;
        end
        if (cls == CLS_SW) begin
            w.iord       = ADDR_ALU_OUT;
            w.mem_write  = 1'b1;
            seq.words[n] = w;
            n++;
        end
        if (cls inside {CLS_J, CLS_JAL, CLS_JR}) begin
            w.pc_write  = 1'b1;
            w.pc_src    = (cls == CLS_JR) ? PCSRC_ALU : PCSRC_JUMP;
            w.alu_src_a = (cls == CLS_JR) ? SRCA_A : SRCA_PC;   // rs passed through
            if (cls == CLS_JAL) begin
                w.reg_write  = 1'b1;
                w.reg_dst    = DST_RA;
                w.mem_to_reg = WB_PC;
            end
            seq.words[n] = w;
            n++;
        end
        if (trap) begin
            w.iord      = ADDR_EXC_VEC;
            w.alu_src_b = SRCB_FOUR;
            w.alu_op    = ALU_SUB;
            w.exc_cause = (cls == CLS_ILLEGAL) ? EXC_ILLEGAL : EXC_OVERFLOW;
            for (i = 0; i < EXC_WAIT; i++) begin
                seq.words[n] = w;
                n++;
            end
            w.iord       = ADDR_PC;
            w.exc_cause  = EXC_NONE;
            w.epc_write  = 1'b1;
            w.pc_write   = 1'b1;
            w.pc_src     = PCSRC_EXC_VEC;
            seq.words[n] = w;
            n++;
        end
        seq.len = 5'(n);
        return seq;
    endfunction

    task automatic compare_word(ctrl_word_t expected, int idx, int step);
        checks++;
        if (ctrl !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: instr %0d cycle %0d ctrl %h, expected %h",
                     $time, idx, step, ctrl, expected);
        end
    endtask

    initial begin
        word_seq_t  seq;
        ctrl_word_t sp_word;
        int         k;
        int         j;
        done               = 1'b0;
        checks             = 0;
        errors             = 0;
        sp_word            = '0;
        sp_word.reg_write  = 1'b1;
        sp_word.reg_dst    = DST_SP;
        sp_word.mem_to_reg = WB_SP_INIT;
        @(posedge clk);   // First reset edge has loaded ctrl
        @(negedge clk);
        while (reset) begin
            compare_word('0, -1, 0);
            @(negedge clk);
        end
        compare_word(sp_word, -1, 1);   // Single SP write after reset
        for (k = 0; k < NUM_INSTR; k++) begin
            seq = expected_sequence(instr_list[k].cls, instr_list[k].alu_op, ovf_list[k]);
            for (j = 0; j < seq.len; j++) begin
                @(negedge clk);
                compare_word(seq.words[j], k, j);
            end
        end
        done = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/control_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit_tb;

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int  NUM_INSTR  = 200;
    localparam int  MAX_CYCLES = 20;   // Per instruction, with margin
    localparam real CLK_PERIOD = 8.0;

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    funct_t     funct;
    logic       overflow;
    ctrl_word_t ctrl;

    decoded_t [NUM_INSTR-1:0] instr_list;
    logic     [NUM_INSTR-1:0] ovf_list;
    opcode_t                  op_list [NUM_INSTR];
    funct_t                   fn_list [NUM_INSTR];
    logic                     done;
    int                       checks;
    int                       errors;
    int                       issued;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    control_unit uut (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    control_checker #(.NUM_INSTR(NUM_INSTR)) u_checker (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr_list (instr_list),
        .ovf_list   (ovf_list),
        .done       (done),
        .checks     (checks),
        .errors     (errors)
    );

    function automatic logic is_supported(opcode_t op, funct_t fn);
        if (op == OP_RTYPE)
            return fn inside {FN_ADD, FN_SUB, FN_AND, FN_JR};
        return op inside {OP_ADDI, OP_ADDIU, OP_LW, OP_SW, OP_J, OP_JAL};
    endfunction

    task automatic set_entry(int i, opcode_t op, instr_class_t cls, alu_op_t aop);
        op_list[i]           = op;
        instr_list[i].cls    = cls;
        instr_list[i].alu_op = aop;
    endtask

    task automatic build_program();
        int i;
        for (i = 0; i < NUM_INSTR; i++) begin
            fn_list[i]  = funct_t'($urandom_range(63, 0));   // Don't care outside R-type
            ovf_list[i] = 1'($urandom_range(1, 0));
            case ($urandom_range(10, 0))
                0: begin
                    set_entry(i, OP_RTYPE, CLS_ALU_R, ALU_ADD);
                    fn_list[i] = FN_ADD;
                end
                1: begin
                    set_entry(i, OP_RTYPE, CLS_ALU_R, ALU_SUB);
                    fn_list[i] = FN_SUB;
                end
                2: begin
                    set_entry(i, OP_RTYPE, CLS_ALU_R, ALU_AND);
                    fn_list[i] = FN_AND;
                end
                3: set_entry(i, OP_ADDI, CLS_ADDI, ALU_ADD);
                4: set_entry(i, OP_ADDIU, CLS_ADDIU, ALU_ADD);
                5: set_entry(i, OP_LW, CLS_LW, ALU_ADD);
                6: set_entry(i, OP_SW, CLS_SW, ALU_ADD);
                7: set_entry(i, OP_J, CLS_J, ALU_PASS);
                8: set_entry(i, OP_JAL, CLS_JAL, ALU_PASS);
                9: begin
                    set_entry(i, OP_RTYPE, CLS_JR, ALU_PASS);
                    fn_list[i] = FN_JR;
                end
                default: begin
                    set_entry(i, OP_RTYPE, CLS_ILLEGAL, ALU_PASS);
                    if ($urandom_range(1, 0) == 1)
                        op_list[i] = opcode_t'($urandom_range(63, 0));
                    while (is_supported(op_list[i], fn_list[i]))
                        op_list[i] = opcode_t'($urandom_range(63, 0));
                end
            endcase
        end
    endtask

    // Datapath side: IR contents after ir_write, overflow in the ALU cycle
    initial begin
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        issued   = 0;
        void'($urandom(80));
        build_program();
        forever begin
            @(negedge clk);
            overflow <= 1'b0;
            if (ctrl.ir_write && issued < NUM_INSTR) begin
                opcode <= op_list[issued];
                funct  <= fn_list[issued];
                issued++;
            end
            if (ctrl.alu_reg_write && issued > 0)
                overflow <= ovf_list[issued-1];
        end
    end

    initial begin
        wait (done === 1'b1);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        #(NUM_INSTR * MAX_CYCLES * CLK_PERIOD);
        $display("Timeout: the checker did not get through all instructions");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- control_unit.f
source/cpu_isa_pkg.sv
source/ctrl_pkg.sv
source/instr_decoder.sv
source/state_sequencer.sv
source/control_word_gen.sv
source/control_unit.sv
bench/clock_gen.sv
bench/control_checker.sv
bench/control_unit_tb.sv

//--- source/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire                       clk,
    input  wire                       reset,
    input  wire cpu_isa_pkg::opcode_t opcode,
    input  wire cpu_isa_pkg::funct_t  funct,
    input  wire                       overflow,
    output ctrl_pkg::ctrl_word_t      ctrl
);

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    decoded_t decoded;
    decoded_t instr;
    state_t   next_state;

    instr_decoder u_decoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    state_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .decoded    (decoded),
        .overflow   (overflow),
        .state      (),
        .next_state (next_state),
        .instr      (instr)
    );

    control_word_gen u_word_gen (
        .clk        (clk),
        .reset      (reset),
        .next_state (next_state),
        .instr      (instr),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

//--- source/control_word_gen.sv
`timescale 1ns/100ps
`default_nettype none

module control_word_gen (
    input  wire                        clk,
    input  wire                        reset,
    input  wire ctrl_pkg::state_t      next_state,
    input  wire cpu_isa_pkg::decoded_t instr,
    output ctrl_pkg::ctrl_word_t       ctrl
);

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_word_t word_d;

    always_comb begin
        word_d = CTRL_IDLE;

        case (next_state)
            ST_SP_INIT: begin
                word_d.reg_write  = 1'b1;
                word_d.reg_dst    = DST_SP;
                word_d.mem_to_reg = WB_SP_INIT;
            end
            ST_FETCH: begin
                word_d.iord      = ADDR_PC;
                word_d.alu_src_a = SRCA_PC;     // PC + 4
                word_d.alu_src_b = SRCB_FOUR;
                word_d.alu_op    = ALU_ADD;
            end
            ST_IR_LOAD: begin
                word_d.iord      = ADDR_PC;
                word_d.alu_src_a = SRCA_PC;
                word_d.alu_src_b = SRCB_FOUR;
                word_d.alu_op    = ALU_ADD;
                word_d.pc_src    = PCSRC_ALU;
                word_d.pc_write  = 1'b1;
                word_d.ir_write  = 1'b1;
            end
            ST_REG_READ: begin
                word_d.a_write = 1'b1;
                word_d.b_write = 1'b1;
            end
            ST_ALU_R: begin
                word_d.alu_src_a     = SRCA_A;
                word_d.alu_src_b     = SRCB_B;
                word_d.alu_op        = instr.alu_op;
                word_d.alu_reg_write = 1'b1;
            end
            ST_WB_R: begin
                word_d.reg_write  = 1'b1;
                word_d.reg_dst    = DST_RD;
                word_d.mem_to_reg = WB_ALU_OUT;
            end
            ST_ALU_I, ST_ADDR: begin
                word_d.alu_src_a     = SRCA_A;
                word_d.alu_src_b     = SRCB_IMM;
                word_d.alu_op        = instr.alu_op;
                word_d.alu_reg_write = 1'b1;   // Result or address into ALU_OUT
            end
            ST_WB_I: begin
                word_d.reg_write  = 1'b1;
                word_d.reg_dst    = DST_RT;
                word_d.mem_to_reg = WB_ALU_OUT;
            end
            ST_MEM_READ: word_d.iord = ADDR_ALU_OUT;
            ST_MDR_LOAD: begin
                word_d.iord      = ADDR_ALU_OUT;
                word_d.mdr_write = 1'b1;
            end
            ST_LOAD_WB: begin
                word_d.reg_write  = 1'b1;
                word_d.reg_dst    = DST_RT;
                word_d.mem_to_reg = WB_MDR;
            end
            ST_STORE: begin
                word_d.iord      = ADDR_ALU_OUT;
                word_d.mem_write = 1'b1;
            end
            ST_JUMP: begin
                word_d.pc_src   = PCSRC_JUMP;
                word_d.pc_write = 1'b1;
            end
            ST_JAL_LINK: begin
                word_d.pc_src     = PCSRC_JUMP;
                word_d.pc_write   = 1'b1;
                word_d.reg_write  = 1'b1;
                word_d.reg_dst    = DST_RA;
                word_d.mem_to_reg = WB_PC;    // Return address
            end
            ST_JR: begin
                word_d.alu_src_a = SRCA_A;
                word_d.alu_op    = ALU_PASS;
                word_d.pc_src    = PCSRC_ALU;
                word_d.pc_write  = 1'b1;
            end
            ST_EXC_VECTOR: begin
                word_d.iord      = ADDR_EXC_VEC;
                word_d.alu_src_a = SRCA_PC;
                word_d.alu_src_b = SRCB_FOUR;
                word_d.alu_op    = ALU_SUB;   // Faulting PC for EPC
                word_d.exc_cause = (instr.cls == CLS_ILLEGAL) ? EXC_ILLEGAL : EXC_OVERFLOW;
            end
            ST_EXC_JUMP: begin
                word_d.alu_src_a = SRCA_PC;
                word_d.alu_src_b = SRCB_FOUR;
                word_d.alu_op    = ALU_SUB;
                word_d.epc_write = 1'b1;
                word_d.pc_src    = PCSRC_EXC_VEC;
                word_d.pc_write  = 1'b1;
            end
            default: ;   // Dispatch issues nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            ctrl <= CTRL_IDLE;
        else
            ctrl <= word_d;
    end

    a_no_store_on_fetch: assert property (
        @(posedge clk) disable iff (reset)
        !(ctrl.mem_write && ctrl.ir_write)
    );

    a_epc_with_pc: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.epc_write |-> ctrl.pc_write
    );

endmodule

`default_nettype wire

//--- source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;

    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT_W-1:0]  funct_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type funct field
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;

    typedef enum logic [3:0] {
        CLS_ALU_R,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_LW,
        CLS_SW,
        CLS_J,
        CLS_JAL,
        CLS_JR,
        CLS_ILLEGAL
    } instr_class_t;

    // Encoding seen by the datapath ALU
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3
    } alu_op_t;

    typedef struct packed {
        instr_class_t cls;
        alu_op_t      alu_op;
    } decoded_t;

endpackage

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [4:0] {
        ST_SP_INIT,
        ST_FETCH,
        ST_IR_LOAD,
        ST_REG_READ,
        ST_DISPATCH,
        ST_ALU_R,
        ST_WB_R,
        ST_ALU_I,
        ST_WB_I,
        ST_ADDR,
        ST_MEM_READ,
        ST_MDR_LOAD,
        ST_LOAD_WB,
        ST_STORE,
        ST_JUMP,
        ST_JAL_LINK,
        ST_JR,
        ST_EXC_VECTOR,
        ST_EXC_JUMP
    } state_t;

    // Memory address select
    typedef enum logic [1:0] {ADDR_PC, ADDR_ALU_OUT, ADDR_EXC_VEC} addr_sel_t;

    typedef enum logic [1:0] {SRCA_PC, SRCA_A} src_a_t;

    typedef enum logic [1:0] {SRCB_B, SRCB_FOUR, SRCB_IMM} src_b_t;

    typedef enum logic [1:0] {PCSRC_ALU, PCSRC_JUMP, PCSRC_EXC_VEC} pc_src_t;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_SP, DST_RA} reg_dst_t;

    // Register file write data
    typedef enum logic [1:0] {WB_ALU_OUT, WB_MDR, WB_SP_INIT, WB_PC} wb_src_t;

    typedef enum logic [1:0] {EXC_NONE, EXC_ILLEGAL, EXC_OVERFLOW} exc_cause_t;

    typedef struct packed {
        logic                 pc_write;
        logic                 ir_write;
        logic                 mem_write;
        logic                 a_write;
        logic                 b_write;
        logic                 mdr_write;
        logic                 alu_reg_write;
        logic                 epc_write;
        logic                 reg_write;
        addr_sel_t            iord;
        src_a_t               alu_src_a;
        src_b_t               alu_src_b;
        cpu_isa_pkg::alu_op_t alu_op;
        pc_src_t              pc_src;
        reg_dst_t             reg_dst;
        wb_src_t              mem_to_reg;
        exc_cause_t           exc_cause;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

    // Wait lengths in cycles
    localparam int FETCH_WAIT = 3;
    localparam int MEM_WAIT   = 2;
    localparam int EXC_WAIT   = 8;
    localparam int WAIT_W     = 4;

endpackage

`default_nettype wire

//--- source/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire cpu_isa_pkg::opcode_t opcode,
    input  wire cpu_isa_pkg::funct_t  funct,
    output cpu_isa_pkg::decoded_t     decoded
);

    import cpu_isa_pkg::*;

    always_comb begin
        decoded.cls    = CLS_ILLEGAL;   // Anything not matched below traps
        decoded.alu_op = ALU_PASS;

        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD: begin
                        decoded.cls    = CLS_ALU_R;
                        decoded.alu_op = ALU_ADD;
                    end
                    FN_SUB: begin
                        decoded.cls    = CLS_ALU_R;
                        decoded.alu_op = ALU_SUB;
                    end
                    FN_AND: begin
                        decoded.cls    = CLS_ALU_R;
                        decoded.alu_op = ALU_AND;
                    end
                    FN_JR: decoded.cls = CLS_JR;
                    default: ;
                endcase
            end
            OP_ADDI: begin
                decoded.cls    = CLS_ADDI;
                decoded.alu_op = ALU_ADD;
            end
            OP_ADDIU: begin
                decoded.cls    = CLS_ADDIU;
                decoded.alu_op = ALU_ADD;
            end
            OP_LW: begin
                decoded.cls    = CLS_LW;
                decoded.alu_op = ALU_ADD;   // base + offset
            end
            OP_SW: begin
                decoded.cls    = CLS_SW;
                decoded.alu_op = ALU_ADD;
            end
            OP_J:    decoded.cls = CLS_J;
            OP_JAL:  decoded.cls = CLS_JAL;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/state_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module state_sequencer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpu_isa_pkg::decoded_t decoded,
    input  wire                        overflow,
    output ctrl_pkg::state_t           state,
    output ctrl_pkg::state_t           next_state,
    output cpu_isa_pkg::decoded_t      instr
);

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] wait_cnt_next;

    always_comb begin
        next_state = state;

        case (state)
            // Cycle after reset release only arms the SP write
            ST_SP_INIT: begin
                if (wait_cnt != '0)
                    next_state = ST_FETCH;
            end
            ST_FETCH: begin
                if (wait_cnt == WAIT_W'(FETCH_WAIT - 1))
                    next_state = ST_IR_LOAD;
            end
            ST_IR_LOAD:  next_state = ST_REG_READ;
            ST_REG_READ: next_state = ST_DISPATCH;
            ST_DISPATCH: begin
                case (instr.cls)
                    CLS_ALU_R:           next_state = ST_ALU_R;
                    CLS_ADDI, CLS_ADDIU: next_state = ST_ALU_I;
                    CLS_LW, CLS_SW:      next_state = ST_ADDR;
                    CLS_J:               next_state = ST_JUMP;
                    CLS_JAL:             next_state = ST_JAL_LINK;
                    CLS_JR:              next_state = ST_JR;
                    default:             next_state = ST_EXC_VECTOR;
                endcase
            end
            ST_ALU_R: next_state = overflow ? ST_EXC_VECTOR : ST_WB_R;
            ST_ALU_I: begin
                // addiu never traps
                if (overflow && instr.cls == CLS_ADDI)
                    next_state = ST_EXC_VECTOR;
                else
                    next_state = ST_WB_I;
            end
            ST_ADDR: next_state = (instr.cls == CLS_LW) ? ST_MEM_READ : ST_STORE;
            ST_MEM_READ: begin
                if (wait_cnt == WAIT_W'(MEM_WAIT - 1))
                    next_state = ST_MDR_LOAD;
            end
            ST_MDR_LOAD: next_state = ST_LOAD_WB;
            ST_EXC_VECTOR: begin
                if (wait_cnt == WAIT_W'(EXC_WAIT - 1))
                    next_state = ST_EXC_JUMP;
            end
            default: next_state = ST_FETCH;   // All single-cycle tails
        endcase
    end

    // Counts cycles spent in a state that loops on itself
    assign wait_cnt_next = (next_state == state) ? wait_cnt + 1'b1 : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_SP_INIT;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            wait_cnt <= wait_cnt_next;
        end
    end

    // IR is settled by the read cycle
    always_ff @(posedge clk) begin
        if (state == ST_REG_READ)
            instr <= decoded;
    end

    a_wait_bound: assert property (
        @(posedge clk) disable iff (reset)
        wait_cnt < WAIT_W'(EXC_WAIT)
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {[ST_SP_INIT:ST_EXC_JUMP]}
    );

endmodule

`default_nettype wire
